// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_core
RTL_TOP    ?= core_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation passed
FAIL_MSG   ?= Simulation failed
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS := verilog/isa_pkg.sv verilog/pipe_pkg.sv verilog/fetch_stage.sv \
            verilog/decoder.sv verilog/reg_file.sv verilog/hazard_unit.sv \
            verilog/alu.sv verilog/core_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	fi
	@echo "Result: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/core_checker.sv ====
`timescale 1ns/1ps

module core_checker #(
    parameter logic [pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      inst_en,
    input  logic                      inst_ok,
    input  logic [pipe_pkg::XLEN-1:0] inst_addr,
    input  logic                      data_en,
    input  logic                      data_ok,
    input  logic [3:0]                data_wen,
    input  logic [pipe_pkg::XLEN-1:0] data_addr,
    input  logic [pipe_pkg::XLEN-1:0] data_wdata,
    output logic                      done,
    output int                        value_errors,
    output int                        rule_errors
);
    import pipe_pkg::*;

    // Expected stores in program order
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              exp_test [$];

    int              seen = 0;
    int              mismatches = 0;
    int              violations = 0;
    logic            all_seen = 1'b0;
    logic            first_cycle = 1'b1;
    logic            inst_waiting = 1'b0;
    logic            data_waiting = 1'b0;
    logic [XLEN-1:0] held_inst_addr;
    logic [XLEN-1:0] held_data_addr;
    logic [XLEN-1:0] held_data_wdata;
    logic [3:0]      held_data_wen;

    assign done         = all_seen;
    assign value_errors = mismatches;
    assign rule_errors  = violations;

    task automatic add_expected(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                                input int test);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_test.push_back(test);
    endtask

    function automatic string test_name(input int id);
        case (id)
            1:       return "alu";
            2:       return "forwarding";
            3:       return "load_use";
            4:       return "branch";
            default: return "store";
        endcase
    endfunction

    task automatic compare_value(input string test, input string what,
                                 input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("** Error [%s] %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic report_violation(input string what);
        violations++;
        $display("Port check at %0t: %s", $time, what);
    endtask

    task automatic check_store();
        string name;
        if (seen >= exp_addr.size()) begin
            report_violation($sformatf("store of %h to %h after the last expected store",
                                       data_wdata, data_addr));
        end else begin
            name = test_name(exp_test[seen]);
            compare_value(name, "store address", exp_addr[seen], data_addr);
            compare_value(name, "store data", exp_data[seen], data_wdata);
            seen++;
            if (seen == exp_addr.size()) begin
                all_seen = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            compare_value("reset", "data_en in reset", '0, XLEN'(data_en));
            first_cycle  = 1'b1;
            inst_waiting = 1'b0;
            data_waiting = 1'b0;
        end else begin
            if (first_cycle) begin
                compare_value("reset", "data_en after reset", '0, XLEN'(data_en));
                compare_value("reset", "inst_en after reset", XLEN'(1), XLEN'(inst_en));
                compare_value("reset", "first inst_addr", RESET_PC, inst_addr);
                first_cycle = 1'b0;
            end
            if (inst_waiting && (!inst_en || inst_addr !== held_inst_addr)) begin
                report_violation("instruction request dropped or changed while inst_ok was low");
            end
            if (data_waiting && (!data_en || data_addr !== held_data_addr ||
                data_wdata !== held_data_wdata || data_wen !== held_data_wen)) begin
                report_violation("data request dropped or changed while data_ok was low");
            end
            if (data_en && data_wen != 4'h0 && data_wen != 4'hf) begin
                report_violation($sformatf("data_wen is %h, neither a load nor a store", data_wen));
            end
            if (data_en && data_ok && data_wen != 4'h0) begin
                check_store();
            end
            inst_waiting    = inst_en && !inst_ok;
            data_waiting    = data_en && !data_ok;
            held_inst_addr  = inst_addr;
            held_data_addr  = data_addr;
            held_data_wdata = data_wdata;
            held_data_wen   = data_wen;
        end
    end

endmodule

// ==== dv/core_testdata.txt ====
# P <instruction word>, loaded in order from the reset PC
# S <store address> <store data> <test id: 1 alu, 2 forwarding, 3 load_use, 4 branch>
P 24010007  # addiu $1, $0, 7
P 2422fffd  # addiu $2, $1, -3
P 00221823  # subu  $3, $1, $2
P 00232021  # addu  $4, $1, $3
P ac040100  # sw    $4, 0x100($0)
P ac030104  # sw    $3, 0x104($0)
P 3c051234  # lui   $5, 0x1234
P 34a5567f  # ori   $5, $5, 0x567f
P 00a43024  # and   $6, $5, $4
P 2408fffb  # addiu $8, $0, -5
P 0103382a  # slt   $7, $8, $3
P 00c74825  # or    $9, $6, $7
P ac050108  # sw    $5, 0x108($0)
P ac09010c  # sw    $9, 0x10c($0)
P 8c0a0104  # lw    $10, 0x104($0)
P 014a5821  # addu  $11, $10, $10
P ac0b0110  # sw    $11, 0x110($0)
P 116a0004  # beq   $11, $10, +4 (not taken)
P 240c0001  # addiu $12, $0, 1 (delay slot)
P 15800003  # bne   $12, $0, +3 (taken)
P ac0c0114  # sw    $12, 0x114($0) (delay slot)
P 240c0063  # addiu $12, $0, 99 (skipped)
P ac0c0120  # sw    $12, 0x120($0) (skipped)
P 10000002  # beq   $0, $0, +2 (taken)
P 258d0002  # addiu $13, $12, 2 (delay slot)
P ac0d0120  # sw    $13, 0x120($0) (skipped)
P ac0d0118  # sw    $13, 0x118($0)
P 15a3fffd  # bne   $13, $3, -3 (not taken)
P ac0d011c  # sw    $13, 0x11c($0) (delay slot)
P 240e0055  # addiu $14, $0, 0x55
P ac0e0124  # sw    $14, 0x124($0)
P 1000ffff  # beq   $0, $0, -1 (self-loop)
P 00000000  # nop (delay slot)
S 00000100 0000000a 2
S 00000104 00000003 1
S 00000108 1234567f 1
S 0000010c 0000000b 1
S 00000110 00000006 3
S 00000114 00000001 4
S 00000118 00000003 4
S 0000011c 00000003 4
S 00000124 00000055 4

// ==== dv/tb_core.sv ====
`timescale 1ns/1ps

module tb_core;
    import pipe_pkg::*;
    import isa_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC       = '0;
    localparam int              MEM_WORDS      = 256;
    localparam int              TIMEOUT_CYCLES = 5000;

    logic            clk;
    logic            arst_n;
    logic            inst_ok;
    logic [XLEN-1:0] inst_data;
    logic            data_ok;
    logic [XLEN-1:0] data_data;
    logic            inst_en;
    logic [XLEN-1:0] inst_addr;
    logic            data_en;
    logic [3:0]      data_wen;
    logic [XLEN-1:0] data_addr;
    logic [XLEN-1:0] data_wdata;

    logic            store_done;
    int              value_errors;
    int              rule_errors;
    int              tb_errors;

    logic [XLEN-1:0] imem [MEM_WORDS];
    logic [XLEN-1:0] dmem [MEM_WORDS];

    // Cycles left before the next ok, -1 while no request is counted
    int              inst_wait;
    int              data_wait;

    core_top #(
        .RESET_PC (RESET_PC)
    ) core_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_ok    (inst_ok),
        .inst_data  (inst_data),
        .data_ok    (data_ok),
        .data_data  (data_data),
        .inst_en    (inst_en),
        .inst_addr  (inst_addr),
        .data_en    (data_en),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata)
    );

    core_checker #(
        .RESET_PC (RESET_PC)
    ) core_checker_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_en      (inst_en),
        .inst_ok      (inst_ok),
        .inst_addr    (inst_addr),
        .data_en      (data_en),
        .data_ok      (data_ok),
        .data_wen     (data_wen),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .done         (store_done),
        .value_errors (value_errors),
        .rule_errors  (rule_errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // P lines fill program memory, S lines go to the checker
    task automatic load_testdata();
        int              fd;
        int              n;
        int              test;
        string           line;
        byte             tag;
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] last_branch;
        logic [7:0]      word_index;
        word_index = RESET_PC[9:2];
        fd = $fopen("dv/core_testdata.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("Could not open dv/core_testdata.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1) begin
                    tag = line.getc(0);
                    if (tag == "P") begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h", word);
                        imem[word_index] = word;
                        word_index++;
                    end else if (tag == "S") begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %d",
                                    word, value, test);
                        core_checker_inst.add_expected(word, value, test);
                    end
                end
            end
            $fclose(fd);
            // Program must close with a BEQ onto itself and a delay slot
            last_branch = imem[word_index - 8'd2];
            if (opcode_e'(last_branch[31:26]) != OP_BEQ || last_branch[15:0] != 16'hffff) begin
                tb_errors++;
                $display("Program in dv/core_testdata.txt does not end in a BEQ self-loop");
            end
        end
    endtask

    task automatic serve_inst_port();
        if (!inst_en) begin
            inst_ok = 1'b0;
        end else begin
            if (inst_wait < 0) begin
                inst_wait = int'($urandom_range(3, 0));
            end
            if (inst_wait == 0) begin
                inst_ok   = 1'b1;
                inst_data = imem[inst_addr[9:2]];
                inst_wait = -1;
            end else begin
                inst_ok = 1'b0;
                inst_wait--;
            end
        end
    endtask

    task automatic serve_data_port();
        if (!data_en) begin
            data_ok = 1'b0;
        end else begin
            if (data_wait < 0) begin
                data_wait = int'($urandom_range(3, 0));
            end
            if (data_wait == 0) begin
                data_ok = 1'b1;
                if (data_wen != 4'h0) begin
                    dmem[data_addr[9:2]] = data_wdata;
                end else begin
                    data_data = dmem[data_addr[9:2]];
                end
                data_wait = -1;
            end else begin
                data_ok = 1'b0;
                data_wait--;
            end
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h5d3c));
        arst_n    = 1'b0;
        inst_ok   = 1'b0;
        inst_data = '0;
        data_ok   = 1'b0;
        data_data = '0;
        tb_errors = 0;
        inst_wait = -1;
        data_wait = -1;
        imem      = '{default: '0};
        dmem      = '{default: '0};
        load_testdata();

        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        cycles = 0;
        while (!store_done && cycles < TIMEOUT_CYCLES) begin
            serve_inst_port();
            serve_data_port();
            @(negedge clk);
            cycles++;
        end
        if (!store_done) begin
            tb_errors++;
            $display("Timeout: not all expected stores were seen within %0d cycles",
                     TIMEOUT_CYCLES);
        end

        $display("Errors: %0d value, %0d port or order, %0d testbench",
                 value_errors, rule_errors, tb_errors);
        if (value_errors == 0 && rule_errors == 0 && tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/hazard_unit.sv
verilog/alu.sv
verilog/core_top.sv
dv/core_checker.sv
dv/tb_core.sv

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  pipe_pkg::alu_op_e         op,
    input  logic [pipe_pkg::XLEN-1:0] a,
    input  logic [pipe_pkg::XLEN-1:0] b,
    output logic [pipe_pkg::XLEN-1:0] y
);
    import pipe_pkg::*;

    logic less;

    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {{(XLEN-1){1'b0}}, less};
            // Immediate goes to the upper half
            ALU_LUI: y = b << 16;
            default: y = '0;
        endcase
    end

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/1ps

module core_top #(
    parameter logic [pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      inst_ok,
    input  logic [pipe_pkg::XLEN-1:0] inst_data,
    input  logic                      data_ok,
    input  logic [pipe_pkg::XLEN-1:0] data_data,
    output logic                      inst_en,
    output logic [pipe_pkg::XLEN-1:0] inst_addr,
    output logic                      data_en,
    output logic [3:0]                data_wen,
    output logic [pipe_pkg::XLEN-1:0] data_addr,
    output logic [pipe_pkg::XLEN-1:0] data_wdata
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                  en_if;
    logic                  en_id_ex;
    logic                  en_ex_mem;
    logic                  en_mem_wb;
    logic                  id_bubble;
    fwd_sel_e              fwd_rs;
    fwd_sel_e              fwd_rt;

    logic [XLEN-1:0]       if_id_instr;
    logic [XLEN-1:0]       if_id_pc;

    logic [REG_ADDR_W-1:0] id_rs;
    logic [REG_ADDR_W-1:0] id_rt;
    logic [REG_ADDR_W-1:0] id_dest;
    logic [XLEN-1:0]       id_imm_ext;
    logic                  id_use_imm;
    alu_op_e               id_alu_op;
    mem_op_e               id_mem_op;
    logic                  id_reg_wen;
    logic                  id_is_branch;
    logic                  id_branch_ne;
    logic [XLEN-1:0]       reg_rs_data;
    logic [XLEN-1:0]       reg_rt_data;
    logic [XLEN-1:0]       rs_value;
    logic [XLEN-1:0]       rt_value;
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;

    logic [XLEN-1:0]       id_ex_a;
    logic [XLEN-1:0]       id_ex_b;
    logic [XLEN-1:0]       id_ex_store;
    alu_op_e               id_ex_alu_op;
    mem_op_e               id_ex_mem_op;
    logic [REG_ADDR_W-1:0] id_ex_dest;
    logic                  id_ex_reg_wen;
    logic [XLEN-1:0]       ex_result;

    logic [XLEN-1:0]       ex_mem_result;
    logic [XLEN-1:0]       ex_mem_store;
    mem_op_e               ex_mem_mem_op;
    logic [REG_ADDR_W-1:0] ex_mem_dest;
    logic                  ex_mem_reg_wen;
    logic [XLEN-1:0]       mem_result;
    logic                  data_done;
    logic [XLEN-1:0]       load_hold;

    logic [XLEN-1:0]       mem_wb_result;
    logic [REG_ADDR_W-1:0] mem_wb_dest;
    logic                  mem_wb_reg_wen;

    function automatic logic [XLEN-1:0] pick_operand(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] ex_val,
        input logic [XLEN-1:0] mem_val
    );
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_val;
            default: return reg_val;
        endcase
    endfunction

    hazard_unit hazard_unit_inst (
        .inst_en     (inst_en),
        .inst_ok     (inst_ok),
        .data_en     (data_en),
        .data_ok     (data_ok),
        .id_rs       (id_rs),
        .id_rt       (id_rt),
        .ex_dest     (id_ex_dest),
        .mem_dest    (ex_mem_dest),
        .ex_reg_wen  (id_ex_reg_wen),
        .mem_reg_wen (ex_mem_reg_wen),
        .ex_mem_op   (id_ex_mem_op),
        .en_if       (en_if),
        .en_id_ex    (en_id_ex),
        .en_ex_mem   (en_ex_mem),
        .en_mem_wb   (en_mem_wb),
        .id_bubble   (id_bubble),
        .fwd_rs      (fwd_rs),
        .fwd_rt      (fwd_rt)
    );

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .en_if         (en_if),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .inst_ok       (inst_ok),
        .inst_data     (inst_data),
        .inst_en       (inst_en),
        .inst_addr     (inst_addr),
        .if_id_instr   (if_id_instr),
        .if_id_pc      (if_id_pc)
    );

    decoder decoder_inst (
        .instr     (if_id_instr),
        .rs        (id_rs),
        .rt        (id_rt),
        .dest      (id_dest),
        .imm_ext   (id_imm_ext),
        .use_imm   (id_use_imm),
        .alu_op    (id_alu_op),
        .mem_op    (id_mem_op),
        .reg_wen   (id_reg_wen),
        .is_branch (id_is_branch),
        .branch_ne (id_branch_ne)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .raddr_a (id_rs),
        .raddr_b (id_rt),
        .waddr   (mem_wb_dest),
        .wen     (mem_wb_reg_wen),
        .wdata   (mem_wb_result),
        .rdata_a (reg_rs_data),
        .rdata_b (reg_rt_data)
    );

    assign rs_value = pick_operand(fwd_rs, reg_rs_data, ex_result, mem_result);
    assign rt_value = pick_operand(fwd_rt, reg_rt_data, ex_result, mem_result);

    // Branch resolves in decode, target relative to the delay slot
    assign branch_taken  = id_is_branch && ((rs_value == rt_value) != id_branch_ne);
    assign branch_target = if_id_pc + XLEN'(4) + {id_imm_ext[XLEN-3:0], 2'b00};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex_mem_op  <= MEM_NONE;
            id_ex_reg_wen <= 1'b0;
        end else if (en_id_ex) begin
            id_ex_mem_op  <= id_bubble ? MEM_NONE : id_mem_op;
            id_ex_reg_wen <= id_bubble ? 1'b0 : id_reg_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (en_id_ex) begin
            id_ex_a      <= rs_value;
            id_ex_b      <= id_use_imm ? id_imm_ext : rt_value;
            id_ex_store  <= rt_value;
            id_ex_alu_op <= id_alu_op;
            id_ex_dest   <= id_dest;
        end
    end

    alu alu_inst (
        .op (id_ex_alu_op),
        .a  (id_ex_a),
        .b  (id_ex_b),
        .y  (ex_result)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem_mem_op  <= MEM_NONE;
            ex_mem_reg_wen <= 1'b0;
            data_done      <= 1'b0;
        end else begin
            if (en_ex_mem) begin
                ex_mem_mem_op  <= id_ex_mem_op;
                ex_mem_reg_wen <= id_ex_reg_wen;
            end
            // Access finished but the pipe is held by fetch
            if (en_mem_wb) begin
                data_done <= 1'b0;
            end else if (data_en && data_ok) begin
                data_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_ex_mem) begin
            ex_mem_result <= ex_result;
            ex_mem_store  <= id_ex_store;
            ex_mem_dest   <= id_ex_dest;
        end
        if (data_en && data_ok) begin
            load_hold <= data_data;
        end
    end

    assign data_en    = (ex_mem_mem_op != MEM_NONE) && !data_done;
    assign data_wen   = (ex_mem_mem_op == MEM_STORE) ? 4'hf : 4'h0;
    assign data_addr  = ex_mem_result;
    assign data_wdata = ex_mem_store;

    assign mem_result = (ex_mem_mem_op != MEM_LOAD) ? ex_mem_result :
                        data_done ? load_hold : data_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb_reg_wen <= 1'b0;
        end else if (en_mem_wb) begin
            mem_wb_reg_wen <= ex_mem_reg_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (en_mem_wb) begin
            mem_wb_result <= mem_result;
            mem_wb_dest   <= ex_mem_dest;
        end
    end

    // Waiting data access holds the whole request
    assert property (@(posedge clk) disable iff (!arst_n)
        data_en && !data_ok |=> data_en && $stable(data_addr) &&
                                $stable(data_wdata) && $stable(data_wen));

endmodule

// ==== verilog/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  logic [pipe_pkg::XLEN-1:0]       instr,
    output logic [isa_pkg::REG_ADDR_W-1:0]  rs,
    output logic [isa_pkg::REG_ADDR_W-1:0]  rt,
    output logic [isa_pkg::REG_ADDR_W-1:0]  dest,
    output logic [pipe_pkg::XLEN-1:0]       imm_ext,
    output logic                            use_imm,
    output pipe_pkg::alu_op_e               alu_op,
    output pipe_pkg::mem_op_e               mem_op,
    output logic                            reg_wen,
    output logic                            is_branch,
    output logic                            branch_ne
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rd;
    logic [IMM_W-1:0]      imm;
    logic                  zero_ext;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm    = instr[15:0];

    assign imm_ext = zero_ext ? {{(XLEN-IMM_W){1'b0}}, imm}
                              : {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};

    always_comb begin
        dest      = rt;
        use_imm   = 1'b1;
        zero_ext  = 1'b0;
        alu_op    = ALU_ADD;
        mem_op    = MEM_NONE;
        reg_wen   = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                dest    = rd;
                use_imm = 1'b0;
                reg_wen = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    // Includes sll $0 (the canonical nop)
                    default: reg_wen = 1'b0;
                endcase
            end
            OP_ADDIU: reg_wen = 1'b1;
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
                reg_wen  = 1'b1;
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                zero_ext = 1'b1;
                reg_wen  = 1'b1;
            end
            OP_LW: begin
                mem_op  = MEM_LOAD;
                reg_wen = 1'b1;
            end
            OP_SW:  mem_op = MEM_STORE;
            OP_BEQ: is_branch = 1'b1;
            OP_BNE: begin
                is_branch = 1'b1;
                branch_ne = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter logic [pipe_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      en_if,
    input  logic                      branch_taken,
    input  logic [pipe_pkg::XLEN-1:0] branch_target,
    input  logic                      inst_ok,
    input  logic [pipe_pkg::XLEN-1:0] inst_data,
    output logic                      inst_en,
    output logic [pipe_pkg::XLEN-1:0] inst_addr,
    output logic [pipe_pkg::XLEN-1:0] if_id_instr,
    output logic [pipe_pkg::XLEN-1:0] if_id_pc
);
    import pipe_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] held_instr;
    logic            held_valid;
    logic [XLEN-1:0] fetched;

    // A word that arrived while the pipe was stalled is kept until decode takes it
    assign inst_en   = !held_valid;
    assign inst_addr = pc;
    assign fetched   = held_valid ? held_instr : inst_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= RESET_PC;
            held_valid  <= 1'b0;
            if_id_instr <= '0;
        end else if (en_if) begin
            pc          <= branch_taken ? branch_target : pc + XLEN'(4);
            held_valid  <= 1'b0;
            if_id_instr <= fetched;
        end else if (inst_en && inst_ok) begin
            held_valid  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (en_if) begin
            if_id_pc <= pc;
        end
        if (inst_en && inst_ok && !en_if) begin
            held_instr <= inst_data;
        end
    end

    // Waiting fetch keeps its address
    assert property (@(posedge clk) disable iff (!arst_n)
        inst_en && !inst_ok |=> inst_en && $stable(inst_addr));

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic                           inst_en,
    input  logic                           inst_ok,
    input  logic                           data_en,
    input  logic                           data_ok,
    input  logic [isa_pkg::REG_ADDR_W-1:0] id_rs,
    input  logic [isa_pkg::REG_ADDR_W-1:0] id_rt,
    input  logic [isa_pkg::REG_ADDR_W-1:0] ex_dest,
    input  logic [isa_pkg::REG_ADDR_W-1:0] mem_dest,
    input  logic                           ex_reg_wen,
    input  logic                           mem_reg_wen,
    input  pipe_pkg::mem_op_e              ex_mem_op,
    output logic                           en_if,
    output logic                           en_id_ex,
    output logic                           en_ex_mem,
    output logic                           en_mem_wb,
    output logic                           id_bubble,
    output pipe_pkg::fwd_sel_e             fwd_rs,
    output pipe_pkg::fwd_sel_e             fwd_rt
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic port_stall;
    logic load_use;

    // Newest producer wins
    function automatic fwd_sel_e select_src(input logic [REG_ADDR_W-1:0] src);
        if (src == '0) begin
            return FWD_REG;
        end
        if (ex_reg_wen && ex_dest == src) begin
            return FWD_EX;
        end
        if (mem_reg_wen && mem_dest == src) begin
            return FWD_MEM;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_rs = select_src(id_rs);
        fwd_rt = select_src(id_rt);
    end

    assign port_stall = (inst_en && !inst_ok) || (data_en && !data_ok);
    assign load_use   = (ex_mem_op == MEM_LOAD) && (ex_dest != '0) &&
                        (ex_dest == id_rs || ex_dest == id_rt);

    assign en_if     = !port_stall && !load_use;
    assign en_id_ex  = !port_stall;
    assign en_ex_mem = !port_stall;
    assign en_mem_wb = !port_stall;
    assign id_bubble = load_use;

endmodule

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    // Register index and immediate field widths
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

    // Data words and addresses
    localparam int XLEN = 32;

    // Execute unit operation
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // Data port access of an instruction
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    // Source of a decode operand
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX,
        FWD_MEM
    } fwd_sel_e;

endpackage

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0] waddr,
    input  logic                           wen,
    input  logic [pipe_pkg::XLEN-1:0]      wdata,
    output logic [pipe_pkg::XLEN-1:0]      rdata_a,
    output logic [pipe_pkg::XLEN-1:0]      rdata_b
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0]       regs [2**REG_ADDR_W];
    logic                  wr_live;

    assign wr_live = wen && (waddr != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // Writeback bypass, $0 always zero
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (wr_live && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (wr_live && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule
